// ==== dv/tb_mem_subsys.sv ====
`default_nettype none

module tb_mem_subsys;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MEM_WORDS = 64;
  localparam int M0_OPS    = 120;
  localparam int M1_OPS    = 120;
  localparam int TIMEOUT   = 40 * (MEM_WORDS + M0_OPS + M1_OPS);

  logic             clock = 1'b0;
  logic             arst_n;
  logic [1:0][31:0] araddr;
  logic [1:0]       arvalid;
  logic [1:0]       rready;
  wire  [1:0]       arready;
  wire  [1:0][31:0] rdata;
  wire  [1:0][1:0]  rresp;
  wire  [1:0]       rvalid;
  bus_pkg::addr_t   awaddr;
  logic             awvalid;
  bus_pkg::data_t   wdata;
  bus_pkg::strb_t   wstrb;
  logic             wvalid;
  logic             bready;
  wire              awready;
  wire              wready;
  wire              bvalid;
  wire bus_pkg::resp_t bresp;

  bus_pkg::data_t   model [MEM_WORDS];
  logic [31:0]      lcg_state [2];
  logic [31:0]      last_lo [2];
  logic [1:0]       pending;
  logic             write_pending;
  logic             traffic_done;
  int unsigned      cycles = 0;
  int unsigned      checks;
  int unsigned      errors;

  mem_subsys #(
    .MEM_WORDS(MEM_WORDS)
  ) mem_subsys_i (
    .clock(clock), .arst_n(arst_n),
    .araddr_0(araddr[0]), .arvalid_0(arvalid[0]), .arready_0(arready[0]),
    .rready_0(rready[0]), .rdata_0(rdata[0]), .rresp_0(rresp[0]), .rvalid_0(rvalid[0]),
    .araddr_1(araddr[1]), .arvalid_1(arvalid[1]), .arready_1(arready[1]),
    .rready_1(rready[1]), .rdata_1(rdata[1]), .rresp_1(rresp[1]), .rvalid_1(rvalid[1]),
    .awaddr_1(awaddr), .awvalid_1(awvalid), .awready_1(awready),
    .wdata_1(wdata), .wstrb_1(wstrb), .wvalid_1(wvalid), .wready_1(wready),
    .bready_1(bready), .bresp_1(bresp), .bvalid_1(bvalid)
  );

  always #20 clock = ~clock;

  always @(posedge clock) begin
    if (arst_n) begin
      cycles++;
      if (cycles >= TIMEOUT) begin
        $display("timeout: traffic did not finish within %0d cycles", TIMEOUT);
        $display("TEST FAILED");
        $finish;
      end
    end
  end

  // Separate streams per master keep each driver's sequence independent of the other
  function automatic logic [31:0] rand_next(input int m);
    lcg_state[m] = lcg_state[m] * 32'd1664525 + 32'd1013904223;
    return lcg_state[m];
  endfunction

  function automatic logic in_sram(input bus_pkg::addr_t addr);
    return addr >= bus_pkg::SRAM_BASE && addr < bus_pkg::SRAM_BASE + MEM_WORDS * 4;
  endfunction

  function automatic int word_of(input bus_pkg::addr_t addr);
    return int'((addr >> 2) % MEM_WORDS);
  endfunction

  // Mostly SRAM, with CLINT words, addresses just past the window and unmapped space
  function automatic bus_pkg::addr_t pick_addr(input int m);
    logic [31:0] r;
    r = rand_next(m);
    case (r[31:28])
      4'd11, 4'd12: return bus_pkg::CLINT_MTIME_LO;
      4'd13: return bus_pkg::CLINT_MTIME_HI;
      4'd14: return bus_pkg::SRAM_BASE + MEM_WORDS * 4 + 32'({r[11:0], 2'b00});
      4'd15: return 32'h4000_0000 + 32'({r[19:0], 2'b00});
      default: return bus_pkg::SRAM_BASE + 32'(((r >> 8) % MEM_WORDS) * 4);
    endcase
  endfunction

  function automatic logic [31:0] handshake_outputs();
    return 32'({arready, rvalid, awready, wready, bvalid});
  endfunction

  task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic read_op(input int m, input bus_pkg::addr_t addr,
                         output bus_pkg::data_t data, output bus_pkg::resp_t resp);
    logic done;
    done = 1'b0;
    pending[m] = 1'b1;
    araddr[m]  <= addr;
    arvalid[m] <= 1'b1;
    while (!done) begin
      @(posedge clock);
      if (arvalid[m] && arready[m]) arvalid[m] <= 1'b0;
      if (rvalid[m] && rready[m]) begin
        done = 1'b1;
        data = rdata[m];
        resp = rresp[m];
        pending[m] = 1'b0;
      end
      rready[m] <= !done && ((rand_next(m) >> 29) != 0);
    end
  endtask

  task automatic write_op(input bus_pkg::addr_t addr, input bus_pkg::data_t data,
                          input bus_pkg::strb_t strb, output bus_pkg::resp_t resp);
    logic done;
    int   w_wait;
    done = 1'b0;
    // W may trail AW by a few cycles
    w_wait = int'(rand_next(1) >> 30);
    write_pending = 1'b1;
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wstrb   <= strb;
    wvalid  <= (w_wait == 0);
    while (!done) begin
      @(posedge clock);
      if (awvalid && awready) awvalid <= 1'b0;
      if (wvalid && wready) wvalid <= 1'b0;
      if (w_wait > 0) begin
        w_wait--;
        if (w_wait == 0) wvalid <= 1'b1;
      end
      if (bvalid && bready) begin
        done = 1'b1;
        resp = bresp;
        write_pending = 1'b0;
      end
      bready <= !done && ((rand_next(1) >> 29) != 0);
    end
  endtask

  task automatic check_read(input int m, input bus_pkg::addr_t addr,
                            input bus_pkg::data_t data, input bus_pkg::resp_t resp);
    if (in_sram(addr)) begin
      check($sformatf("master %0d sram read data", m), model[word_of(addr)], data);
      check($sformatf("master %0d sram read resp", m), 32'(bus_pkg::RESP_OKAY), 32'(resp));
    end else if (addr == bus_pkg::CLINT_MTIME_LO) begin
      check($sformatf("master %0d mtime low resp", m), 32'(bus_pkg::RESP_OKAY), 32'(resp));
      if (data < last_lo[m]) begin
        errors++;
        $display("master %0d read mtime %0d after an earlier %0d", m, data, last_lo[m]);
      end
      if (data > cycles) begin
        errors++;
        $display("master %0d read mtime %0d after only %0d cycles", m, data, cycles);
      end
      last_lo[m] = data;
    end else if (addr == bus_pkg::CLINT_MTIME_HI) begin
      check($sformatf("master %0d mtime high data", m), 32'd0, data);
      check($sformatf("master %0d mtime high resp", m), 32'(bus_pkg::RESP_OKAY), 32'(resp));
    end else begin
      check($sformatf("master %0d unmapped read data", m), 32'd0, data);
      check($sformatf("master %0d unmapped read resp", m), 32'(bus_pkg::RESP_DECERR), 32'(resp));
    end
  endtask

  // The model takes the write once B has been seen
  task automatic check_write(input bus_pkg::addr_t addr, input bus_pkg::data_t data,
                             input bus_pkg::strb_t strb, input bus_pkg::resp_t resp);
    if (in_sram(addr)) begin
      check("sram write resp", 32'(bus_pkg::RESP_OKAY), 32'(resp));
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) model[word_of(addr)][8*b +: 8] = data[8*b +: 8];
      end
    end else if (addr == bus_pkg::CLINT_MTIME_LO || addr == bus_pkg::CLINT_MTIME_HI) begin
      check("clint write resp", 32'(bus_pkg::RESP_DECERR), 32'(resp));
    end else begin
      check("unmapped write resp", 32'(bus_pkg::RESP_DECERR), 32'(resp));
    end
  endtask

  task automatic fill_memory();
    bus_pkg::data_t data;
    bus_pkg::resp_t resp;
    for (int i = 0; i < MEM_WORDS; i++) begin
      data = rand_next(1);
      write_op(bus_pkg::SRAM_BASE + 32'(i * 4), data, 4'hf, resp);
      check_write(bus_pkg::SRAM_BASE + 32'(i * 4), data, 4'hf, resp);
    end
  endtask

  // Fetch always idles at least one cycle so stores can win the bus
  task automatic run_master0();
    bus_pkg::addr_t addr;
    bus_pkg::data_t data;
    bus_pkg::resp_t resp;
    for (int i = 0; i < M0_OPS; i++) begin
      repeat (1 + (rand_next(0) >> 29)) @(posedge clock);
      addr = pick_addr(0);
      read_op(0, addr, data, resp);
      check_read(0, addr, data, resp);
    end
  endtask

  task automatic run_master1();
    bus_pkg::addr_t addr;
    bus_pkg::data_t data;
    bus_pkg::strb_t strb;
    bus_pkg::resp_t resp;
    for (int i = 0; i < M1_OPS; i++) begin
      repeat (rand_next(1) >> 30) @(posedge clock);
      addr = pick_addr(1);
      if ((rand_next(1) >> 31) != 0) begin
        data = rand_next(1);
        strb = bus_pkg::strb_t'(rand_next(1) >> 28);
        write_op(addr, data, strb, resp);
        check_write(addr, data, strb, resp);
      end else begin
        read_op(1, addr, data, resp);
        check_read(1, addr, data, resp);
      end
    end
  endtask

  // Sampled on the falling edge, halfway between input changes and output updates
  task automatic watch_responses();
    logic [1:0]     r_stall;
    bus_pkg::data_t r_data [2];
    bus_pkg::resp_t r_resp [2];
    logic           b_stall;
    bus_pkg::resp_t b_resp;
    r_stall = '0;
    b_stall = 1'b0;
    while (!traffic_done) begin
      @(negedge clock);
      for (int m = 0; m < 2; m++) begin
        if (rvalid[m] && !pending[m]) begin
          errors++;
          $display("master %0d saw rvalid with no read outstanding", m);
        end
        if (r_stall[m]) begin
          check($sformatf("master %0d stalled rvalid", m), 32'd1, 32'(rvalid[m]));
          check($sformatf("master %0d stalled rdata", m), r_data[m], rdata[m]);
          check($sformatf("master %0d stalled rresp", m), 32'(r_resp[m]), 32'(rresp[m]));
        end
        r_stall[m] = rvalid[m] && !rready[m];
        r_data[m]  = rdata[m];
        r_resp[m]  = rresp[m];
      end
      if (bvalid && !write_pending) begin
        errors++;
        $display("master 1 saw bvalid with no write outstanding");
      end
      if (b_stall) begin
        check("stalled bvalid", 32'd1, 32'(bvalid));
        check("stalled bresp", 32'(b_resp), 32'(bresp));
      end
      b_stall = bvalid && !bready;
      b_resp  = bresp;
    end
  endtask

  initial begin
    arst_n        = 1'b0;
    araddr        = '0;
    arvalid       = '0;
    rready        = '0;
    awaddr        = '0;
    awvalid       = 1'b0;
    wdata         = '0;
    wstrb         = '0;
    wvalid        = 1'b0;
    bready        = 1'b0;
    pending       = '0;
    write_pending = 1'b0;
    traffic_done  = 1'b0;
    last_lo[0]    = '0;
    last_lo[1]    = '0;
    checks        = 0;
    errors        = 0;
    lcg_state[0]  = 32'hcc2c_bc4b;
    lcg_state[1]  = rand_next(0);

    repeat (2) begin
      @(negedge clock);
      check("handshake outputs in reset", 32'd0, handshake_outputs());
    end
    @(posedge clock);
    arst_n <= 1'b1;
    @(negedge clock);
    check("handshake outputs after reset", 32'd0, handshake_outputs());
    @(posedge clock);

    fork
      begin
        fill_memory();
        fork
          run_master0();
          run_master1();
        join
        traffic_done = 1'b1;
      end
      watch_responses();
    join

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/bus_arbiter.sv ====
`default_nettype none

module bus_arbiter #(
  parameter int unsigned MEM_WORDS = 1024
) (
  input  wire logic           clock,
  input  wire logic           arst_n,

  // Instruction fetch master
  input  wire bus_pkg::addr_t araddr_0,
  input  wire logic           arvalid_0,
  output logic                arready_0,
  input  wire logic           rready_0,
  output bus_pkg::data_t      rdata_0,
  output bus_pkg::resp_t      rresp_0,
  output logic                rvalid_0,

  // Load/store master
  input  wire bus_pkg::addr_t araddr_1,
  input  wire logic           arvalid_1,
  output logic                arready_1,
  input  wire logic           rready_1,
  output bus_pkg::data_t      rdata_1,
  output bus_pkg::resp_t      rresp_1,
  output logic                rvalid_1,
  input  wire bus_pkg::addr_t awaddr_1,
  input  wire logic           awvalid_1,
  output logic                awready_1,
  input  wire bus_pkg::data_t wdata_1,
  input  wire bus_pkg::strb_t wstrb_1,
  input  wire logic           wvalid_1,
  output logic                wready_1,
  input  wire logic           bready_1,
  output bus_pkg::resp_t      bresp_1,
  output logic                bvalid_1,

  // SRAM
  output bus_pkg::addr_t      s_araddr,
  output logic                s_arvalid,
  input  wire logic           s_arready,
  output logic                s_rready,
  input  wire bus_pkg::data_t s_rdata,
  input  wire bus_pkg::resp_t s_rresp,
  input  wire logic           s_rvalid,
  output bus_pkg::addr_t      s_awaddr,
  output logic                s_awvalid,
  input  wire logic           s_awready,
  output bus_pkg::data_t      s_wdata,
  output bus_pkg::strb_t      s_wstrb,
  output logic                s_wvalid,
  input  wire logic           s_wready,
  output logic                s_bready,
  input  wire bus_pkg::resp_t s_bresp,
  input  wire logic           s_bvalid,

  // CLINT
  output bus_pkg::addr_t      c_araddr,
  output logic                c_arvalid,
  input  wire logic           c_arready,
  output logic                c_rready,
  input  wire bus_pkg::data_t c_rdata,
  input  wire bus_pkg::resp_t c_rresp,
  input  wire logic           c_rvalid
);

  typedef enum logic [1:0] {IDLE, READ, WRITE} state_e;
  typedef enum logic [1:0] {TGT_SRAM, TGT_CLINT, TGT_ERR} target_e;

  localparam bus_pkg::addr_t SRAM_BYTES = bus_pkg::addr_t'(MEM_WORDS * 4);

  state_e         state;
  target_e        target;
  logic           grant;

  logic           req_any;
  logic           req_master;
  logic           req_write;
  bus_pkg::addr_t req_addr;

  logic           rd_active;
  logic           wr_active;
  logic           sel_0;
  logic           sel_1;
  logic           is_err;
  bus_pkg::addr_t m_araddr;
  logic           m_arvalid;
  logic           m_rready;

  logic           t_arready;
  bus_pkg::data_t t_rdata;
  bus_pkg::resp_t t_rresp;
  logic           t_rvalid;
  logic           t_awready;
  logic           t_wready;
  bus_pkg::resp_t t_bresp;
  logic           t_bvalid;

  logic           err_rvalid;
  logic           err_aw_done;
  logic           err_w_done;
  logic           err_bvalid;
  logic           err_ar_take;
  logic           err_aw_take;
  logic           err_w_take;
  logic           err_b_fire;

  // The CLINT is read-only, so a write there falls through to the error reply
  function automatic target_e decode(bus_pkg::addr_t addr, logic is_write);
    if (addr - bus_pkg::SRAM_BASE < SRAM_BYTES) begin
      return TGT_SRAM;
    end
    if (!is_write && (addr == bus_pkg::CLINT_MTIME_LO || addr == bus_pkg::CLINT_MTIME_HI)) begin
      return TGT_CLINT;
    end
    return TGT_ERR;
  endfunction

  // Fetch reads win, then load/store reads, then stores
  assign req_any    = arvalid_0 || arvalid_1 || awvalid_1;
  assign req_master = !arvalid_0;
  assign req_write  = !arvalid_0 && !arvalid_1;
  assign req_addr   = arvalid_0 ? araddr_0 : (arvalid_1 ? araddr_1 : awaddr_1);

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state  <= IDLE;
      grant  <= 1'b0;
      target <= TGT_ERR;
    end else begin
      case (state)
        IDLE: begin
          if (req_any) begin
            state  <= req_write ? WRITE : READ;
            grant  <= req_master;
            target <= decode(req_addr, req_write);
          end
        end
        READ: begin
          if (t_rvalid && m_rready) state <= IDLE;
        end
        WRITE: begin
          if (t_bvalid && bready_1) state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign rd_active = (state == READ);
  assign wr_active = (state == WRITE);
  assign sel_0     = rd_active && !grant;
  assign sel_1     = rd_active && grant;
  assign is_err    = (target == TGT_ERR);

  assign m_araddr  = grant ? araddr_1 : araddr_0;
  assign m_arvalid = rd_active && (grant ? arvalid_1 : arvalid_0);
  assign m_rready  = grant ? rready_1 : rready_0;

  assign s_araddr  = m_araddr;
  assign s_arvalid = m_arvalid && (target == TGT_SRAM);
  assign s_rready  = rd_active && (target == TGT_SRAM) && m_rready;
  assign s_awaddr  = awaddr_1;
  assign s_awvalid = wr_active && (target == TGT_SRAM) && awvalid_1;
  assign s_wdata   = wdata_1;
  assign s_wstrb   = wstrb_1;
  assign s_wvalid  = wr_active && (target == TGT_SRAM) && wvalid_1;
  assign s_bready  = wr_active && (target == TGT_SRAM) && bready_1;

  assign c_araddr  = m_araddr;
  assign c_arvalid = m_arvalid && (target == TGT_CLINT);
  assign c_rready  = rd_active && (target == TGT_CLINT) && m_rready;

  always_comb begin
    t_arready = !err_rvalid;
    t_rdata   = '0;
    t_rresp   = bus_pkg::RESP_DECERR;
    t_rvalid  = err_rvalid;
    t_awready = !err_aw_done && !err_bvalid;
    t_wready  = !err_w_done && !err_bvalid;
    t_bresp   = bus_pkg::RESP_DECERR;
    t_bvalid  = err_bvalid;
    if (target == TGT_SRAM) begin
      t_arready = s_arready;
      t_rdata   = s_rdata;
      t_rresp   = s_rresp;
      t_rvalid  = s_rvalid;
      t_awready = s_awready;
      t_wready  = s_wready;
      t_bresp   = s_bresp;
      t_bvalid  = s_bvalid;
    end else if (target == TGT_CLINT) begin
      t_arready = c_arready;
      t_rdata   = c_rdata;
      t_rresp   = c_rresp;
      t_rvalid  = c_rvalid;
    end
  end

  // Error reply with the same one cycle latency as the SRAM
  assign err_ar_take = is_err && m_arvalid && !err_rvalid;
  assign err_aw_take = is_err && wr_active && awvalid_1 && !err_aw_done && !err_bvalid;
  assign err_w_take  = is_err && wr_active && wvalid_1 && !err_w_done && !err_bvalid;
  assign err_b_fire  = (err_aw_done || err_aw_take) && (err_w_done || err_w_take);

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      err_rvalid  <= 1'b0;
      err_aw_done <= 1'b0;
      err_w_done  <= 1'b0;
      err_bvalid  <= 1'b0;
    end else begin
      if (err_ar_take) begin
        err_rvalid <= 1'b1;
      end else if (err_rvalid && m_rready) begin
        err_rvalid <= 1'b0;
      end
      if (err_b_fire) begin
        err_aw_done <= 1'b0;
        err_w_done  <= 1'b0;
        err_bvalid  <= 1'b1;
      end else begin
        if (err_aw_take) err_aw_done <= 1'b1;
        if (err_w_take) err_w_done <= 1'b1;
        if (err_bvalid && bready_1) err_bvalid <= 1'b0;
      end
    end
  end

  assign arready_0 = sel_0 && t_arready;
  assign rvalid_0  = sel_0 && t_rvalid;
  assign rdata_0   = sel_0 ? t_rdata : '0;
  assign rresp_0   = sel_0 ? t_rresp : bus_pkg::RESP_OKAY;

  assign arready_1 = sel_1 && t_arready;
  assign rvalid_1  = sel_1 && t_rvalid;
  assign rdata_1   = sel_1 ? t_rdata : '0;
  assign rresp_1   = sel_1 ? t_rresp : bus_pkg::RESP_OKAY;

  assign awready_1 = wr_active && t_awready;
  assign wready_1  = wr_active && t_wready;
  assign bvalid_1  = wr_active && t_bvalid;
  assign bresp_1   = wr_active ? t_bresp : bus_pkg::RESP_OKAY;

  a_grant_stable: assert property (@(posedge clock) disable iff (!arst_n)
    state != IDLE |=> state == IDLE || ($stable(grant) && $stable(target)));

  // Every target answers one cycle after its AR, so read data only follows the own request
  a_rvalid_owner_0: assert property (@(posedge clock) disable iff (!arst_n)
    $rose(rvalid_0) |-> $past(arvalid_0 && arready_0));

  a_rvalid_owner_1: assert property (@(posedge clock) disable iff (!arst_n)
    $rose(rvalid_1) |-> $past(arvalid_1 && arready_1));

endmodule

`default_nettype wire

// ==== rtl/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

  // Every transfer is one aligned 32-bit beat, so one address and one data width
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;

  // One strobe bit per byte lane of data_t
  typedef logic [3:0] strb_t;

  typedef logic [1:0] resp_t;

  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_DECERR = 2'd3;

  // Only the two mtime words of the CLINT are mapped
  localparam addr_t CLINT_MTIME_LO = 32'h0200_0048;
  localparam addr_t CLINT_MTIME_HI = 32'h0200_004c;

  // The SRAM window starts here and its size follows the SRAM depth
  localparam addr_t SRAM_BASE = 32'h8000_0000;

endpackage

`default_nettype wire

// ==== rtl/clint.sv ====
`default_nettype none

module clint (
  input  wire logic           clock,
  input  wire logic           arst_n,

  input  wire bus_pkg::addr_t araddr,
  input  wire logic           arvalid,
  output logic                arready,

  input  wire logic           rready,
  output bus_pkg::data_t      rdata,
  output bus_pkg::resp_t      rresp,
  output logic                rvalid
);

  logic [63:0] mtime;
  logic        ar_take;

  // Only one read is held at a time
  assign arready = !rvalid;
  assign ar_take = arvalid && arready;
  assign rresp   = bus_pkg::RESP_OKAY;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      mtime <= '0;
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      rvalid <= 1'b0;
    end else if (ar_take) begin
      rvalid <= 1'b1;
    end else if (rvalid && rready) begin
      rvalid <= 1'b0;
    end
  end

  // Address bit 2 picks the high word at 0x0200_004c
  always_ff @(posedge clock) begin
    if (ar_take) begin
      rdata <= araddr[2] ? mtime[63:32] : mtime[31:0];
    end
  end

  // mtime keeps running, but a stalled reply keeps the value it sampled
  a_rdata_stable: assert property (@(posedge clock) disable iff (!arst_n)
    rvalid && !rready |=> $stable(rdata));

endmodule

`default_nettype wire

// ==== rtl/mem_subsys.sv ====
`default_nettype none

module mem_subsys #(
  parameter int unsigned MEM_WORDS = 1024
) (
  input  wire logic           clock,
  input  wire logic           arst_n,

  input  wire bus_pkg::addr_t araddr_0,
  input  wire logic           arvalid_0,
  output wire logic           arready_0,
  input  wire logic           rready_0,
  output wire bus_pkg::data_t rdata_0,
  output wire bus_pkg::resp_t rresp_0,
  output wire logic           rvalid_0,

  input  wire bus_pkg::addr_t araddr_1,
  input  wire logic           arvalid_1,
  output wire logic           arready_1,
  input  wire logic           rready_1,
  output wire bus_pkg::data_t rdata_1,
  output wire bus_pkg::resp_t rresp_1,
  output wire logic           rvalid_1,
  input  wire bus_pkg::addr_t awaddr_1,
  input  wire logic           awvalid_1,
  output wire logic           awready_1,
  input  wire bus_pkg::data_t wdata_1,
  input  wire bus_pkg::strb_t wstrb_1,
  input  wire logic           wvalid_1,
  output wire logic           wready_1,
  input  wire logic           bready_1,
  output wire bus_pkg::resp_t bresp_1,
  output wire logic           bvalid_1
);

  // Arbiter to SRAM
  bus_pkg::addr_t s_araddr;
  bus_pkg::addr_t s_awaddr;
  bus_pkg::data_t s_rdata;
  bus_pkg::data_t s_wdata;
  bus_pkg::strb_t s_wstrb;
  bus_pkg::resp_t s_rresp;
  bus_pkg::resp_t s_bresp;
  logic           s_arvalid, s_arready, s_rready, s_rvalid;
  logic           s_awvalid, s_awready, s_wvalid, s_wready;
  logic           s_bready, s_bvalid;

  // Arbiter to CLINT
  bus_pkg::addr_t c_araddr;
  bus_pkg::data_t c_rdata;
  bus_pkg::resp_t c_rresp;
  logic           c_arvalid, c_arready, c_rready, c_rvalid;

  bus_arbiter #(
    .MEM_WORDS(MEM_WORDS)
  ) bus_arbiter_i (
    .*
  );

  sram_slave #(
    .MEM_WORDS(MEM_WORDS)
  ) sram_slave_i (
    .clock   (clock),
    .arst_n  (arst_n),
    .araddr  (s_araddr),
    .arvalid (s_arvalid),
    .arready (s_arready),
    .rready  (s_rready),
    .rdata   (s_rdata),
    .rresp   (s_rresp),
    .rvalid  (s_rvalid),
    .awaddr  (s_awaddr),
    .awvalid (s_awvalid),
    .awready (s_awready),
    .wdata   (s_wdata),
    .wstrb   (s_wstrb),
    .wvalid  (s_wvalid),
    .wready  (s_wready),
    .bready  (s_bready),
    .bresp   (s_bresp),
    .bvalid  (s_bvalid)
  );

  clint clint_i (
    .clock   (clock),
    .arst_n  (arst_n),
    .araddr  (c_araddr),
    .arvalid (c_arvalid),
    .arready (c_arready),
    .rready  (c_rready),
    .rdata   (c_rdata),
    .rresp   (c_rresp),
    .rvalid  (c_rvalid)
  );

endmodule

`default_nettype wire

// ==== rtl/sram_slave.sv ====
`default_nettype none

module sram_slave #(
  parameter int unsigned MEM_WORDS = 1024
) (
  input  wire logic           clock,
  input  wire logic           arst_n,

  input  wire bus_pkg::addr_t araddr,
  input  wire logic           arvalid,
  output logic                arready,

  input  wire logic           rready,
  output bus_pkg::data_t      rdata,
  output bus_pkg::resp_t      rresp,
  output logic                rvalid,

  input  wire bus_pkg::addr_t awaddr,
  input  wire logic           awvalid,
  output logic                awready,

  input  wire bus_pkg::data_t wdata,
  input  wire bus_pkg::strb_t wstrb,
  input  wire logic           wvalid,
  output logic                wready,

  input  wire logic           bready,
  output bus_pkg::resp_t      bresp,
  output logic                bvalid
);

  localparam int unsigned IDX_W = $clog2(MEM_WORDS);

  bus_pkg::data_t mem [MEM_WORDS];

  logic             ar_take;
  logic             aw_take;
  logic             w_take;
  logic             aw_full;
  logic             w_full;
  logic             wr_fire;
  logic [IDX_W-1:0] aw_idx;
  logic [IDX_W-1:0] wr_idx;
  bus_pkg::data_t   w_data;
  bus_pkg::data_t   wr_data;
  bus_pkg::strb_t   w_strb;
  bus_pkg::strb_t   wr_strb;

  // Word index from the bits above the byte offset, wrapped to the depth
  function automatic logic [IDX_W-1:0] word_idx(bus_pkg::addr_t addr);
    return IDX_W'((addr >> 2) % MEM_WORDS);
  endfunction

  assign rresp = bus_pkg::RESP_OKAY;
  assign bresp = bus_pkg::RESP_OKAY;

  assign arready = !rvalid;
  assign ar_take = arvalid && arready;

  // AW and W each get one holding slot and are closed while B is pending
  assign awready = !aw_full && !bvalid;
  assign wready  = !w_full && !bvalid;
  assign aw_take = awvalid && awready;
  assign w_take  = wvalid && wready;

  // Either half may arrive in the same cycle that completes the pair
  assign wr_idx  = aw_full ? aw_idx : word_idx(awaddr);
  assign wr_data = w_full ? w_data : wdata;
  assign wr_strb = w_full ? w_strb : wstrb;
  assign wr_fire = (aw_full || aw_take) && (w_full || w_take);

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      rvalid  <= 1'b0;
      aw_full <= 1'b0;
      w_full  <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      if (ar_take) begin
        rvalid <= 1'b1;
      end else if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
      if (wr_fire) begin
        aw_full <= 1'b0;
        w_full  <= 1'b0;
        bvalid  <= 1'b1;
      end else begin
        if (aw_take) aw_full <= 1'b1;
        if (w_take) w_full <= 1'b1;
        if (bvalid && bready) bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (aw_take) aw_idx <= word_idx(awaddr);
    if (w_take) begin
      w_data <= wdata;
      w_strb <= wstrb;
    end
    if (wr_fire) begin
      for (int b = 0; b < 4; b++) begin
        if (wr_strb[b]) mem[wr_idx][8*b +: 8] <= wr_data[8*b +: 8];
      end
    end
    if (ar_take) rdata <= mem[word_idx(araddr)];
  end

  a_rvalid_hold: assert property (@(posedge clock) disable iff (!arst_n)
    rvalid && !rready |=> rvalid && $stable(rdata));

  a_bvalid_hold: assert property (@(posedge clock) disable iff (!arst_n)
    bvalid && !bready |=> bvalid);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line in its output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module tb_mem_subsys \
  -o sim_mem_subsys -f sim.f &&
result="$(./obj_dir/sim_mem_subsys)" &&
printf '%s\n' "$result" &&
printf '%s\n' "$result" | grep -qx "TEST PASSED" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }

// ==== sim.f ====
rtl/bus_pkg.sv
rtl/clint.sv
rtl/sram_slave.sv
rtl/bus_arbiter.sv
rtl/mem_subsys.sv
dv/tb_mem_subsys.sv
